/* prefix_alu_pkg.sv */
// Shared width, opcodes and pipeline payload types for the prefix-adder ALU
`default_nettype none

package prefix_alu_pkg;

	// Default operand width, one word
	localparam int DATA_W = 24;

	// Command opcodes
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_ADDC = 3'd1,
		OP_SUB  = 3'd2,
		OP_SUBB = 3'd3,
		OP_CMP  = 3'd4
	} alu_op_e;

	// Where the adder carry-in comes from
	typedef enum logic [1:0] {
		CIN_ZERO = 2'd0,
		CIN_ONE  = 2'd1,
		CIN_FLAG = 2'd2
	} carry_sel_e;

	// Incoming command word
	typedef struct packed {
		alu_op_e             op;
		logic [DATA_W-1:0]   a;
		logic [DATA_W-1:0]   b;
	} alu_cmd_t;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
		logic overflow;
	} alu_flags_t;

	// Decode to execute, y is already complemented for subtraction
	typedef struct packed {
		logic [DATA_W-1:0]   x;
		logic [DATA_W-1:0]   y;
		carry_sel_e          carry_sel;
		logic                write_result;
		logic                is_sub;
	} dec_ctrl_t;

	// Execute to result
	typedef struct packed {
		logic [DATA_W-1:0]   sum;
		logic                carry_out;
		logic                overflow;
		logic                write_result;
	} exe_out_t;

endpackage

`default_nettype wire

/* prefix_adder.sv */
// Sparse parallel-prefix adder of the Harris family with a final grey-cell row
`timescale 1ns/100ps
`default_nettype none

module prefix_adder #(
	parameter int DATA_W = prefix_alu_pkg::DATA_W
) (
	input  logic [DATA_W-1:0] x,
	input  logic [DATA_W-1:0] y,
	input  logic              cin,
	output logic [DATA_W-1:0] sum,
	output logic              cout
);

	// Black/grey levels, span doubles on each one
	localparam int LEVELS = $clog2(DATA_W);

	// Positions shifted up by one, position 0 holds the carry-in
	logic [DATA_W:0] p;
	logic [DATA_W:0] g;

	// Group generate/propagate after each level, level 0 is the raw bits
	wire [DATA_W-1:0] gt [0:LEVELS];
	wire [DATA_W-1:0] pt [0:LEVELS];

	// Group generate from each position down to position 0
	wire [DATA_W-1:0] g_all;

	// Pre-computation
	assign p = {x ^ y, 1'b0};
	assign g = {x & y, cin};

	assign gt[0] = g[DATA_W-1:0];
	assign pt[0] = p[DATA_W-1:0];

	genvar lvl;
	genvar i;

	// Tree over the odd positions only, this is what makes it sparse
	generate
		for (lvl = 1; lvl <= LEVELS; lvl++) begin : g_level
			// Distance to the lower group merged at this level
			localparam int DIST = 1 << (lvl - 1);

			for (i = 0; i < DATA_W; i++) begin : g_bit
				if ((i % 2 == 0) || (i < DIST)) begin : g_pass
					// Even position, or group already reaches bit 0
					assign gt[lvl][i] = gt[lvl-1][i];
					assign pt[lvl][i] = pt[lvl-1][i];
				end else if (i < 2 * DIST) begin : g_grey
					// Merged group ends at position 0
					assign gt[lvl][i] = gt[lvl-1][i] | (pt[lvl-1][i] & gt[lvl-1][i-DIST]);
					// p[0] is zero, so any group down to 0 cannot propagate
					assign pt[lvl][i] = 1'b0;
				end else begin : g_black
					assign gt[lvl][i] = gt[lvl-1][i] | (pt[lvl-1][i] & gt[lvl-1][i-DIST]);
					assign pt[lvl][i] = pt[lvl-1][i] & pt[lvl-1][i-DIST];
				end
			end
		end

		// Extra grey row fills in the even positions from their odd neighbour
		for (i = 0; i < DATA_W; i++) begin : g_fill
			if (i == 0) begin : g_cin
				assign g_all[i] = gt[LEVELS][i];
			end else if (i % 2 == 1) begin : g_odd
				assign g_all[i] = gt[LEVELS][i];
			end else begin : g_even
				assign g_all[i] = gt[LEVELS][i] | (pt[LEVELS][i] & g_all[i-1]);
			end
		end
	endgenerate

	// Post-computation, carry into bit k is the group generate of position k
	assign sum  = p[DATA_W:1] ^ g_all;
	assign cout = g[DATA_W] | (p[DATA_W] & g_all[DATA_W-1]);

endmodule

`default_nettype wire

/* alu_decode.sv */
// Decode stage, registers the command as adder operands and control bits
`timescale 1ns/100ps
`default_nettype none

module alu_decode #(
	parameter int DATA_W = prefix_alu_pkg::DATA_W
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      cmd_valid,
	input  prefix_alu_pkg::alu_cmd_t  cmd,
	output logic                      dec_valid,
	output prefix_alu_pkg::dec_ctrl_t dec
);

	logic                       is_sub;
	logic                       write_result;
	prefix_alu_pkg::carry_sel_e carry_sel;
	logic [DATA_W-1:0]          y_word;

	// Opcode to control bits
	always_comb begin
		// Unknown opcodes fall through as a compare
		is_sub       = 1'b1;
		write_result = 1'b0;
		carry_sel    = prefix_alu_pkg::CIN_ONE;
		case (cmd.op)
			prefix_alu_pkg::OP_ADD: begin
				is_sub       = 1'b0;
				write_result = 1'b1;
				carry_sel    = prefix_alu_pkg::CIN_ZERO;
			end
			prefix_alu_pkg::OP_ADDC: begin
				is_sub       = 1'b0;
				write_result = 1'b1;
				carry_sel    = prefix_alu_pkg::CIN_FLAG;
			end
			prefix_alu_pkg::OP_SUB: begin
				is_sub       = 1'b1;
				write_result = 1'b1;
				carry_sel    = prefix_alu_pkg::CIN_ONE;
			end
			prefix_alu_pkg::OP_SUBB: begin
				is_sub       = 1'b1;
				write_result = 1'b1;
				carry_sel    = prefix_alu_pkg::CIN_FLAG;
			end
			default: begin
				is_sub       = 1'b1;
				write_result = 1'b0;
				carry_sel    = prefix_alu_pkg::CIN_ONE;
			end
		endcase
	end

	// x - y is x + ~y + carry-in
	assign y_word = is_sub ? ~cmd.b : cmd.b;

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= cmd_valid;
		end
	end

	// Payload only
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			dec.x            <= cmd.a;
			dec.y            <= y_word;
			dec.carry_sel    <= carry_sel;
			dec.write_result <= write_result;
			dec.is_sub       <= is_sub;
		end
	end

endmodule

`default_nettype wire

/* alu_execute.sv */
// Execute stage, adds through the prefix adder and keeps the carry flag
`timescale 1ns/100ps
`default_nettype none

module alu_execute #(
	parameter int DATA_W = prefix_alu_pkg::DATA_W
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      dec_valid,
	input  prefix_alu_pkg::dec_ctrl_t dec,
	output logic                      exe_valid,
	output prefix_alu_pkg::exe_out_t  exe
);

	// Architectural carry, reads as no-borrow after a subtraction
	logic              carry_flag;
	logic              cin;
	logic [DATA_W-1:0] sum;
	logic              cout;
	logic              overflow;

	// Carry-in select
	always_comb begin
		case (dec.carry_sel)
			prefix_alu_pkg::CIN_ZERO: cin = 1'b0;
			prefix_alu_pkg::CIN_ONE:  cin = 1'b1;
			prefix_alu_pkg::CIN_FLAG: cin = carry_flag;
			default:                  cin = 1'b0;
		endcase
	end

	prefix_adder #(
		.DATA_W(DATA_W)
	) i_adder (
		.x   (dec.x),
		.y   (dec.y),
		.cin (cin),
		.sum (sum),
		.cout(cout)
	);

	// Same-sign operands with a sum of the other sign
	assign overflow = (dec.x[DATA_W-1] == dec.y[DATA_W-1]) &&
		(sum[DATA_W-1] != dec.x[DATA_W-1]);

	// Flag moves as the command leaves, so a follower right behind sees it
	always_ff @(posedge clk) begin
		if (rst) begin
			exe_valid  <= 1'b0;
			carry_flag <= 1'b0;
		end else begin
			exe_valid <= dec_valid;
			if (dec_valid) begin
				carry_flag <= cout;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			exe.sum          <= sum;
			exe.carry_out    <= cout;
			exe.overflow     <= overflow;
			exe.write_result <= dec.write_result;
		end
	end

endmodule

`default_nettype wire

/* alu_result.sv */
// Result stage, forms the flags and holds the last written result
`timescale 1ns/100ps
`default_nettype none

module alu_result #(
	parameter int DATA_W = prefix_alu_pkg::DATA_W
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       exe_valid,
	input  prefix_alu_pkg::exe_out_t   exe,
	output logic                       result_valid,
	output logic [DATA_W-1:0]          result,
	output prefix_alu_pkg::alu_flags_t flags
);

	prefix_alu_pkg::alu_flags_t flags_next;

	always_comb begin
		flags_next.zero     = (exe.sum == '0);
		flags_next.negative = exe.sum[DATA_W-1];
		flags_next.carry    = exe.carry_out;
		flags_next.overflow = exe.overflow;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
			result       <= '0;
			flags        <= '0;
		end else begin
			result_valid <= exe_valid;
			// Flags on every item, compare included
			if (exe_valid) begin
				flags <= flags_next;
			end
			if (exe_valid && exe.write_result) begin
				result <= exe.sum;
			end
		end
	end

endmodule

`default_nettype wire

/* prefix_alu_top.sv */
// Three-stage prefix-adder ALU, decode then execute then result
`timescale 1ns/100ps
`default_nettype none

module prefix_alu_top #(
	parameter int DATA_W = prefix_alu_pkg::DATA_W
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       cmd_valid,
	input  prefix_alu_pkg::alu_cmd_t   cmd,
	output logic                       result_valid,
	output logic [DATA_W-1:0]          result,
	output prefix_alu_pkg::alu_flags_t flags
);

	logic                      dec_valid;
	prefix_alu_pkg::dec_ctrl_t dec;
	logic                      exe_valid;
	prefix_alu_pkg::exe_out_t  exe;

	alu_decode #(
		.DATA_W(DATA_W)
	) i_decode (
		.clk      (clk),
		.rst      (rst),
		.cmd_valid(cmd_valid),
		.cmd      (cmd),
		.dec_valid(dec_valid),
		.dec      (dec)
	);

	alu_execute #(
		.DATA_W(DATA_W)
	) i_execute (
		.clk      (clk),
		.rst      (rst),
		.dec_valid(dec_valid),
		.dec      (dec),
		.exe_valid(exe_valid),
		.exe      (exe)
	);

	alu_result #(
		.DATA_W(DATA_W)
	) i_result (
		.clk         (clk),
		.rst         (rst),
		.exe_valid   (exe_valid),
		.exe         (exe),
		.result_valid(result_valid),
		.result      (result),
		.flags       (flags)
	);

endmodule

`default_nettype wire

/* tb_prefix_alu.sv */
// Testbench that replays golden vectors through the prefix-adder ALU and checks each result
`timescale 1ns/100ps
`default_nettype none

module tb_prefix_alu;

	localparam int DATA_W        = prefix_alu_pkg::DATA_W;
	localparam int VEC_W         = 3 * DATA_W + 8;
	localparam int NUM_VEC       = 28;
	localparam int NUM_PASS      = 2;
	localparam int LATENCY       = 3;
	localparam int DRAIN_TIMEOUT = 200;

	typedef struct packed {
		int unsigned                pass_num;
		int unsigned                idx;
		int unsigned                sample_edge;
		logic [DATA_W-1:0]          result;
		prefix_alu_pkg::alu_flags_t flags;
	} expect_t;

	logic                       clk;
	logic                       rst;
	logic                       cmd_valid;
	prefix_alu_pkg::alu_cmd_t   cmd;
	logic                       result_valid;
	logic [DATA_W-1:0]          result;
	prefix_alu_pkg::alu_flags_t flags;

	logic [VEC_W-1:0] golden_mem [0:NUM_VEC-1];
	expect_t          exp_q [$];
	int unsigned      cycle_cnt;
	logic [31:0]      rng_state;
	int               strobe_cnt;
	int               mismatch_errors;
	int               latency_errors;
	int               strobe_errors;
	int               other_errors;

	prefix_alu_top #(
		.DATA_W(DATA_W)
	) i_dut (
		.clk         (clk),
		.rst         (rst),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.result_valid(result_valid),
		.result      (result),
		.flags       (flags)
	);

	always #5 clk = ~clk;

	// Number of rising edges seen so far
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	function automatic logic [31:0] next_random(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check_result(input string name, input logic [DATA_W-1:0] exp_val,
		input logic [DATA_W-1:0] act_val);
		if (act_val !== exp_val) begin
			$display("Mismatch %s result: expected %h, actual %h", name, exp_val, act_val);
			mismatch_errors++;
		end
	endtask

	task automatic check_flags(input string name, input prefix_alu_pkg::alu_flags_t exp_val,
		input prefix_alu_pkg::alu_flags_t act_val);
		if (act_val !== exp_val) begin
			$display("Mismatch %s flags (z n c v): expected %b, actual %b",
				name, exp_val, act_val);
			mismatch_errors++;
		end
	endtask

	// Drives one vector on this edge and queues what should come back
	task automatic drive_command(input int pass_num, input int idx);
		logic [VEC_W-1:0] entry;
		expect_t          item;
		entry = golden_mem[idx];
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd.op    <= prefix_alu_pkg::alu_op_e'(entry[4+3*DATA_W +: 3]);
		cmd.a     <= entry[4+2*DATA_W +: DATA_W];
		cmd.b     <= entry[4+DATA_W +: DATA_W];
		item.pass_num = pass_num;
		item.idx      = idx;
		// The DUT samples this command on the next edge
		item.sample_edge = cycle_cnt + 2;
		item.result      = entry[4 +: DATA_W];
		item.flags       = prefix_alu_pkg::alu_flags_t'(entry[3:0]);
		exp_q.push_back(item);
	endtask

	task automatic drain_results;
		int wait_cnt;
		wait_cnt = 0;
		while (exp_q.size() != 0 && wait_cnt < DRAIN_TIMEOUT) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (exp_q.size() != 0) begin
			$display("Timed out after %0d cycles with %0d results still missing",
				DRAIN_TIMEOUT, exp_q.size());
			other_errors++;
		end
	endtask

	// Outputs sampled on the falling edge
	always @(negedge clk) begin : monitor
		expect_t     head;
		string       name;
		int unsigned lat;
		if (!rst && $isunknown(result_valid)) begin
			$display("Result strobe is unknown at cycle %0d", cycle_cnt);
			strobe_errors++;
		end else if (!rst && result_valid) begin
			strobe_cnt++;
			if (exp_q.size() == 0) begin
				$display("Result strobe at cycle %0d with no command outstanding", cycle_cnt);
				strobe_errors++;
			end else begin
				head = exp_q.pop_front();
				name = $sformatf("pass%0d_vec%0d", head.pass_num, head.idx);
				check_result(name, head.result, result);
				check_flags(name, head.flags, flags);
				// Sampling edge counts as edge 1
				lat = cycle_cnt - head.sample_edge + 1;
				if (lat != LATENCY) begin
					$display("%s came back %0d edges after issue instead of %0d",
						name, lat, LATENCY);
					latency_errors++;
				end
			end
		end
	end

	initial begin
		int gap;
		int total;
		clk             = 1'b0;
		rst             = 1'b1;
		cmd_valid       = 1'b0;
		cmd             = '0;
		cycle_cnt       = 0;
		rng_state       = 32'd60107;
		strobe_cnt      = 0;
		mismatch_errors = 0;
		latency_errors  = 0;
		strobe_errors   = 0;
		other_errors    = 0;

		// Unloaded entries keep an opcode nibble of F and get caught below
		for (int i = 0; i < NUM_VEC; i++) begin
			golden_mem[i] = {4'hF, (VEC_W-4)'(i)};
		end
		$readmemh("prefix_alu_golden.txt", golden_mem);
		for (int i = 0; i < NUM_VEC; i++) begin
			if (golden_mem[i][4+3*DATA_W +: 4] > 4'd4) begin
				$display("Golden entry %0d is missing or has an unknown opcode", i);
				other_errors++;
			end
		end

		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// Back-to-back pass first and a pass with random idle gaps after it
		for (int pass_num = 0; pass_num < NUM_PASS; pass_num++) begin
			for (int idx = 0; idx < NUM_VEC; idx++) begin
				gap = 0;
				if (pass_num > 0) begin
					rng_state = next_random(rng_state);
					gap = int'(rng_state % 32'd4);
				end
				repeat (gap) begin
					@(posedge clk);
					cmd_valid <= 1'b0;
				end
				drive_command(pass_num, idx);
			end
			@(posedge clk);
			cmd_valid <= 1'b0;
			drain_results();
		end

		// Quiet window to catch stray strobes
		repeat (LATENCY + 2) @(posedge clk);
		if (strobe_cnt != NUM_PASS * NUM_VEC) begin
			$display("Saw %0d result strobes but issued %0d commands",
				strobe_cnt, NUM_PASS * NUM_VEC);
			other_errors++;
		end

		total = mismatch_errors + latency_errors + strobe_errors + other_errors;
		$display("Errors: %0d mismatch, %0d latency, %0d strobe, %0d other",
			mismatch_errors, latency_errors, strobe_errors, other_errors);
		if (total == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
prefix_alu_pkg.sv
prefix_adder.sv
alu_decode.sv
alu_execute.sv
alu_result.sv
prefix_alu_top.sv
tb_prefix_alu.sv

/* run_sim.sh */
#!/bin/sh
# Builds the prefix-adder ALU testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_prefix_alu -o sim_prefix_alu

out=$(./obj_dir/sim_prefix_alu)
echo "$out"

# The script succeeds only if the pass line is in the output
echo "$out" | grep -q "^Test passed$"

/* prefix_alu_golden.txt */
// One vector per line, 20 hex digits: op(1) a(6) b(6) result(6) flags(1)
// op 0=ADD 1=ADDC 2=SUB 3=SUBB 4=CMP, flags bits zero,negative,carry,overflow
10000010000020000030
0FFFFFF000001000000A
00000010000010000020
0AAAAAA555555FFFFFF4
07FFFFF0000018000005
0800000800000000000B
0555555555555AAAAAA5
00008000008000010000
20000050000030000022
2000003000005FFFFFE4
28000000000017FFFFF3
40012340012347FFFFFA
40000100000207FFFFF4
2123456123456000000A
0FFFFFF000001000000A
10000010000020000040
0FFFFFF000001000000A
1FFFFFF000000000000A
17FFFFF0000008000005
2000000000001FFFFFF4
30000050000020000022
2000000000001FFFFFF4
3000000000000FFFFFF4
3000001000000000000A
30000090000040000052
10000100000200000310
48000000000010000313
10000000000000000010
